//--- hdl/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath
`define XLEN 32

// instruction memory, word addressed
`define IMEM_DEPTH 64
`define IMEM_AW 6

// fetch queue entries
`define FQ_DEPTH 4

// first fetch address
`define RESET_PC 32'h0000_0000

`endif

//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_t;

    // funct3, arithmetic group
    localparam logic [2:0] F3_ADD = 3'b000;  // also sub, addi
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // funct3, branch group
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    localparam logic [2:0] F3_JALR = 3'b000;

    // funct7 for register-register ops
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B  // lui
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_NONE
    } branch_t;

endpackage

//--- hdl/core_pkg.sv
`include "core_defines.svh"

package core_pkg;

    // one slot of the fetch queue
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [31:0]      inst;
    } fetch_entry_t;

    // one retired instruction as seen on the retire port
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [31:0]      inst;
        logic             rd_we;
        logic [4:0]       rd;
        logic [`XLEN-1:0] rd_data;
    } retire_t;

endpackage

//--- hdl/fetch_queue_if.sv
`timescale 1ns/10ps

interface fetch_queue_if #(
    parameter type entry_t = logic [63:0]
);

    logic   push;        // producer strobe
    entry_t push_entry;
    logic   full;        // level from queue
    logic   pop;         // consumer strobe
    entry_t pop_entry;   // head of queue
    logic   empty;
    logic   flush;       // one cycle, from consumer

    modport prod (
        output push, push_entry,
        input  full, flush
    );

    modport buff (
        input  push, push_entry, pop, flush,
        output full, pop_entry, empty
    );

    modport cons (
        output pop, flush,
        input  pop_entry, empty
    );

endinterface

//--- hdl/fetch_unit.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module fetch_unit (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                run,
    input  logic                imem_we,
    input  logic [`IMEM_AW-1:0] imem_addr,
    input  logic [`XLEN-1:0]    imem_wdata,
    input  logic [`XLEN-1:0]    redirect_pc,
    fetch_queue_if.prod         fq
);

    logic [`XLEN-1:0]     imem [`IMEM_DEPTH];
    logic [`XLEN-1:0]     pc;
    logic [`XLEN-1:0]     pc_next;
    logic [`IMEM_AW-1:0]  fetch_idx;
    core_pkg::fetch_entry_t entry;

    // program load port, only used while run is low
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    assign fetch_idx = pc[`IMEM_AW+1:2];  // word index

    // combinational read, one word per cycle
    always_comb begin
        entry.pc   = pc;
        entry.inst = imem[fetch_idx];
    end

    assign fq.push       = run & ~fq.full & ~fq.flush;
    assign fq.push_entry = entry;

    // redirect wins over sequential fetch; hold while full
    always_comb begin
        if (fq.flush) begin
            pc_next = redirect_pc;
        end else if (fq.push) begin
            pc_next = pc + `XLEN'd4;
        end else begin
            pc_next = pc;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

//--- hdl/fetch_queue.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module fetch_queue #(
    parameter type entry_t = logic [63:0],
    parameter int  DEPTH   = `FQ_DEPTH
) (
    input  logic        clk,
    input  logic        arst_n,
    fetch_queue_if.buff fq
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    entry_t          mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            do_push;
    logic            do_pop;

    assign fq.full  = (count == CW'(DEPTH));
    assign fq.empty = (count == '0);

    // flush takes priority over push
    assign do_push = fq.push & ~fq.full & ~fq.flush;
    assign do_pop  = fq.pop & ~fq.empty;

    assign fq.pop_entry = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= fq.push_entry;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (fq.flush) begin
            wr_ptr <= '0;  // drop everything in flight
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // none, or push and pop together
            endcase
        end
    end

endmodule

//--- hdl/exec_unit.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module exec_unit (
    input  logic             clk,
    input  logic             arst_n,
    fetch_queue_if.cons      fq,
    output logic [`XLEN-1:0] redirect_pc,
    output logic             retire_valid,
    output logic [`XLEN-1:0] retire_pc,
    output logic [31:0]      retire_inst,
    output logic             retire_rd_we,
    output logic [4:0]       retire_rd,
    output logic [`XLEN-1:0] retire_rd_data
);

    core_pkg::fetch_entry_t entry;
    core_pkg::retire_t      ret_q;
    rv_isa_pkg::opcode_t    opcode;
    rv_isa_pkg::alu_op_t    alu_op;
    rv_isa_pkg::branch_t    br_kind;

    logic [`XLEN-1:0] regs [32];
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [4:0]       rs1, rs2, rd;
    logic [`XLEN-1:0] imm_i, imm_u, imm_j, imm_b, imm;
    logic [`XLEN-1:0] rs1_data, rs2_data, alu_a, alu_b, alu_out;
    logic [`XLEN-1:0] wb_data, jump_target;
    logic             src_a_pc, src_b_imm, rd_we, link, is_jump, br_taken, wr_en;

    assign fq.pop = ~fq.empty;  // never stalls
    assign entry  = fq.pop_entry;

    assign opcode = rv_isa_pkg::opcode_t'(entry.inst[6:0]);
    assign funct3 = entry.inst[14:12];
    assign funct7 = entry.inst[31:25];
    assign rs1    = entry.inst[19:15];
    assign rs2    = entry.inst[24:20];
    assign rd     = entry.inst[11:7];

    assign imm_i = {{20{entry.inst[31]}}, entry.inst[31:20]};
    assign imm_u = {entry.inst[31:12], 12'b0};
    assign imm_j = {{12{entry.inst[31]}}, entry.inst[19:12], entry.inst[20],
                    entry.inst[30:21], 1'b0};
    assign imm_b = {{20{entry.inst[31]}}, entry.inst[7], entry.inst[30:25],
                    entry.inst[11:8], 1'b0};

    // decoder; anything unrecognised falls out as a no-op
    always_comb begin
        alu_op    = rv_isa_pkg::ALU_ADD;
        br_kind   = rv_isa_pkg::BR_NONE;
        imm       = imm_i;
        src_a_pc  = 1'b0;
        src_b_imm = 1'b0;
        rd_we     = 1'b0;
        link      = 1'b0;
        is_jump   = 1'b0;
        case (opcode)
            rv_isa_pkg::OP_IMM: begin
                if (funct3 == rv_isa_pkg::F3_ADD) begin  // addi only
                    src_b_imm = 1'b1;
                    rd_we     = 1'b1;
                end
            end
            rv_isa_pkg::OP_REG: begin
                if (funct7 == rv_isa_pkg::F7_BASE ||
                    (funct7 == rv_isa_pkg::F7_SUB && funct3 == rv_isa_pkg::F3_ADD)) begin
                    rd_we = 1'b1;
                    case (funct3)
                        rv_isa_pkg::F3_ADD: alu_op = (funct7 == rv_isa_pkg::F7_SUB) ?
                                                     rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
                        rv_isa_pkg::F3_SLT: alu_op = rv_isa_pkg::ALU_SLT;
                        rv_isa_pkg::F3_XOR: alu_op = rv_isa_pkg::ALU_XOR;
                        rv_isa_pkg::F3_OR:  alu_op = rv_isa_pkg::ALU_OR;
                        rv_isa_pkg::F3_AND: alu_op = rv_isa_pkg::ALU_AND;
                        default:            rd_we  = 1'b0;
                    endcase
                end
            end
            rv_isa_pkg::OP_LUI: begin
                alu_op    = rv_isa_pkg::ALU_PASS_B;
                imm       = imm_u;
                src_b_imm = 1'b1;
                rd_we     = 1'b1;
            end
            rv_isa_pkg::OP_AUIPC: begin
                imm       = imm_u;
                src_a_pc  = 1'b1;
                src_b_imm = 1'b1;
                rd_we     = 1'b1;
            end
            rv_isa_pkg::OP_JAL: begin
                imm       = imm_j;  // target through the alu
                src_a_pc  = 1'b1;
                src_b_imm = 1'b1;
                rd_we     = 1'b1;
                link      = 1'b1;
                is_jump   = 1'b1;
            end
            rv_isa_pkg::OP_JALR: begin
                if (funct3 == rv_isa_pkg::F3_JALR) begin
                    src_b_imm = 1'b1;
                    rd_we     = 1'b1;
                    link      = 1'b1;
                    is_jump   = 1'b1;
                end
            end
            rv_isa_pkg::OP_BRANCH: begin
                imm       = imm_b;
                src_a_pc  = 1'b1;
                src_b_imm = 1'b1;
                case (funct3)
                    rv_isa_pkg::F3_BEQ: br_kind = rv_isa_pkg::BR_EQ;
                    rv_isa_pkg::F3_BNE: br_kind = rv_isa_pkg::BR_NE;
                    rv_isa_pkg::F3_BLT: br_kind = rv_isa_pkg::BR_LT;
                    rv_isa_pkg::F3_BGE: br_kind = rv_isa_pkg::BR_GE;
                    default:            br_kind = rv_isa_pkg::BR_NONE;
                endcase
            end
            default: ;
        endcase
    end

    // x0 hardwired to zero on the read side
    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

    assign alu_a = src_a_pc ? entry.pc : rs1_data;
    assign alu_b = src_b_imm ? imm : rs2_data;

    always_comb begin
        case (alu_op)
            rv_isa_pkg::ALU_SUB:    alu_out = alu_a - alu_b;
            rv_isa_pkg::ALU_AND:    alu_out = alu_a & alu_b;
            rv_isa_pkg::ALU_OR:     alu_out = alu_a | alu_b;
            rv_isa_pkg::ALU_XOR:    alu_out = alu_a ^ alu_b;
            rv_isa_pkg::ALU_SLT:    alu_out = {{(`XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            rv_isa_pkg::ALU_PASS_B: alu_out = alu_b;
            default:                alu_out = alu_a + alu_b;
        endcase
    end

    always_comb begin
        case (br_kind)
            rv_isa_pkg::BR_EQ: br_taken = (rs1_data == rs2_data);
            rv_isa_pkg::BR_NE: br_taken = (rs1_data != rs2_data);
            rv_isa_pkg::BR_LT: br_taken = ($signed(rs1_data) < $signed(rs2_data));
            rv_isa_pkg::BR_GE: br_taken = ($signed(rs1_data) >= $signed(rs2_data));
            default:           br_taken = 1'b0;
        endcase
    end

    assign jump_target = (opcode == rv_isa_pkg::OP_JALR) ? {alu_out[`XLEN-1:1], 1'b0} : alu_out;
    assign redirect_pc = jump_target;
    assign fq.flush    = fq.pop & (br_taken | is_jump);  // same cycle as the pop

    assign wb_data = link ? entry.pc + `XLEN'd4 : alu_out;
    assign wr_en   = rd_we & (rd != 5'd0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (fq.pop && wr_en) begin
            regs[rd] <= wb_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= fq.pop;
        end
    end

    always_ff @(posedge clk) begin
        if (fq.pop) begin
            ret_q.pc      <= entry.pc;
            ret_q.inst    <= entry.inst;
            ret_q.rd_we   <= wr_en;
            ret_q.rd      <= rd;
            ret_q.rd_data <= wb_data;
        end
    end

    assign retire_pc      = ret_q.pc;
    assign retire_inst    = ret_q.inst;
    assign retire_rd_we   = ret_q.rd_we;
    assign retire_rd      = ret_q.rd;
    assign retire_rd_data = ret_q.rd_data;

endmodule

//--- hdl/mini_core_top.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module mini_core_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                run,
    input  logic                imem_we,
    input  logic [`IMEM_AW-1:0] imem_addr,
    input  logic [`XLEN-1:0]    imem_wdata,
    output logic                retire_valid,
    output logic [`XLEN-1:0]    retire_pc,
    output logic [31:0]         retire_inst,
    output logic                retire_rd_we,
    output logic [4:0]          retire_rd,
    output logic [`XLEN-1:0]    retire_rd_data
);

    logic [`XLEN-1:0] redirect_pc;  // valid with flush

    fetch_queue_if #(.entry_t(core_pkg::fetch_entry_t)) fq_if ();

    fetch_unit u_fetch_unit (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .redirect_pc (redirect_pc),
        .fq          (fq_if.prod)
    );

    fetch_queue #(
        .entry_t (core_pkg::fetch_entry_t),
        .DEPTH   (`FQ_DEPTH)
    ) u_fetch_queue (
        .clk    (clk),
        .arst_n (arst_n),
        .fq     (fq_if.buff)
    );

    exec_unit u_exec_unit (
        .clk            (clk),
        .arst_n         (arst_n),
        .fq             (fq_if.cons),
        .redirect_pc    (redirect_pc),
        .retire_valid   (retire_valid),
        .retire_pc      (retire_pc),
        .retire_inst    (retire_inst),
        .retire_rd_we   (retire_rd_we),
        .retire_rd      (retire_rd),
        .retire_rd_data (retire_rd_data)
    );

endmodule

//--- tests/mini_core_sva.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module mini_core_sva (
    input logic                             clk,
    input logic                             arst_n,
    input logic                             push,
    input logic                             pop,
    input logic                             full,
    input logic                             empty,
    input logic [$clog2(`FQ_DEPTH+1)-1:0]   count
);

    int fail_count = 0;

    a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n) push |-> !full)
        else begin
            $error("fetch queue pushed while full");
            fail_count++;
        end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n) pop |-> !empty)
        else begin
            $error("fetch queue popped while empty");
            fail_count++;
        end

    a_count_bound: assert property (@(posedge clk) disable iff (!arst_n) count <= `FQ_DEPTH)
        else begin
            $error("fetch queue count above depth");
            fail_count++;
        end

    // first edge out of reset
    a_empty_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> empty)
        else begin
            $error("fetch queue not empty after reset");
            fail_count++;
        end

endmodule

bind fetch_queue mini_core_sva u_fetch_queue_sva (
    .clk    (clk),
    .arst_n (arst_n),
    .push   (fq.push),
    .pop    (fq.pop),
    .full   (fq.full),
    .empty  (fq.empty),
    .count  (count)
);

//--- tests/mini_core_tb.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module mini_core_tb;

    localparam int max_cycles = 2000;  // about 8 per retirement plus load and reset time

    logic                clk;
    logic                arst_n;
    logic                run;
    logic                imem_we;
    logic [`IMEM_AW-1:0] imem_addr;
    logic [`XLEN-1:0]    imem_wdata;
    logic                retire_valid;
    logic [`XLEN-1:0]    retire_pc;
    logic [31:0]         retire_inst;
    logic                retire_rd_we;
    logic [4:0]          retire_rd;
    logic [`XLEN-1:0]    retire_rd_data;

    logic [31:0]       lfsr;
    logic [31:0]       prog_q [$];
    core_pkg::retire_t expected_q [$];
    int                cycles;
    int                check_count;
    int                error_count;
    int                assert_fails;

    mini_core_top u_mini_core_top (
        .clk            (clk),
        .arst_n         (arst_n),
        .run            (run),
        .imem_we        (imem_we),
        .imem_addr      (imem_addr),
        .imem_wdata     (imem_wdata),
        .retire_valid   (retire_valid),
        .retire_pc      (retire_pc),
        .retire_inst    (retire_inst),
        .retire_rd_we   (retire_rd_we),
        .retire_rd      (retire_rd),
        .retire_rd_data (retire_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [4:0] rd,
                                           input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] opc, input logic [4:0] rd,
                                           input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::OP_JAL};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_isa_pkg::OP_BRANCH};
    endfunction

    function automatic void append_inst(input logic [31:0] inst);
        prog_q.push_back(inst);
    endfunction

    task automatic compare_word(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
                                input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %0t ns: %s got %08h expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic compare_retire(input core_pkg::retire_t got, input core_pkg::retire_t exp,
                                  input string what);
        check_count++;
        if (got.pc !== exp.pc || got.inst !== exp.inst || got.rd_we !== exp.rd_we) begin
            error_count++;
            $display("ERROR %0t ns: %s retired pc=%08h inst=%08h we=%0b", $time, what,
                     got.pc, got.inst, got.rd_we);
            $display("      expected pc=%08h inst=%08h we=%0b", exp.pc, exp.inst, exp.rd_we);
        end else if (exp.rd_we) begin  // data only matters when written
            compare_word(`XLEN'(got.rd), `XLEN'(exp.rd), {what, " rd"});
            compare_word(got.rd_data, exp.rd_data, {what, " rd_data"});
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        arst_n <= 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    // one word per cycle with run low
    task automatic load_program();
        foreach (prog_q[i]) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= `IMEM_AW'(i);
            imem_wdata <= prog_q[i];
            @(negedge clk);
            compare_word(`XLEN'(retire_valid), '0, "retire_valid while loading");
        end
        @(posedge clk);
        imem_we <= 1'b0;
    endtask

    // reference model up to the first jump to itself
    task automatic build_expected();
        logic [31:0]       x [32];
        logic [31:0]       pc, next_pc, inst, a, b, res;
        logic [31:0]       imm_i, imm_u, imm_j, imm_b;
        logic [4:0]        rd;
        logic              we, taken;
        core_pkg::retire_t rec;
        int                steps;
        expected_q.delete();
        foreach (x[i]) x[i] = '0;
        pc = `RESET_PC;
        for (steps = 0; steps < 256; steps++) begin
            inst  = (pc[31:2] < prog_q.size()) ? prog_q[pc[31:2]] : 32'h0;
            rd    = inst[11:7];
            a     = x[inst[19:15]];
            b     = x[inst[24:20]];
            imm_i = {{20{inst[31]}}, inst[31:20]};
            imm_u = {inst[31:12], 12'h000};
            imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            we      = 1'b0;
            taken   = 1'b0;
            res     = '0;
            next_pc = pc + 32'd4;
            case (inst[6:0])
                rv_isa_pkg::OP_IMM: begin
                    we  = (inst[14:12] == 3'b000);  // addi only
                    res = a + imm_i;
                end
                rv_isa_pkg::OP_REG: begin
                    we = 1'b1;
                    case ({inst[31:25], inst[14:12]})
                        10'b0000000_000: res = a + b;
                        10'b0100000_000: res = a - b;
                        10'b0000000_010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        10'b0000000_100: res = a ^ b;
                        10'b0000000_110: res = a | b;
                        10'b0000000_111: res = a & b;
                        default:         we  = 1'b0;
                    endcase
                end
                rv_isa_pkg::OP_LUI: begin
                    we  = 1'b1;
                    res = imm_u;
                end
                rv_isa_pkg::OP_AUIPC: begin
                    we  = 1'b1;
                    res = pc + imm_u;
                end
                rv_isa_pkg::OP_JAL: begin
                    we      = 1'b1;
                    res     = pc + 32'd4;
                    next_pc = pc + imm_j;
                end
                rv_isa_pkg::OP_JALR: begin
                    if (inst[14:12] == 3'b000) begin
                        we      = 1'b1;
                        res     = pc + 32'd4;
                        next_pc = (a + imm_i) & ~32'd1;
                    end
                end
                rv_isa_pkg::OP_BRANCH: begin
                    case (inst[14:12])
                        3'b000:  taken = (a == b);
                        3'b001:  taken = (a != b);
                        3'b100:  taken = ($signed(a) < $signed(b));
                        3'b101:  taken = ($signed(a) >= $signed(b));
                        default: taken = 1'b0;
                    endcase
                    if (taken) begin
                        next_pc = pc + imm_b;
                    end
                end
                default: ;
            endcase
            rec.pc      = pc;
            rec.inst    = inst;
            rec.rd_we   = we && (rd != 5'd0);
            rec.rd      = rd;
            rec.rd_data = res;
            expected_q.push_back(rec);
            if (rec.rd_we) begin
                x[rd] = res;
            end
            if (next_pc == pc) begin
                break;
            end
            pc = next_pc;
        end
    endtask

    task automatic run_program(input string name);
        core_pkg::retire_t obs;
        int                got;
        append_inst(j_type(5'd0, 21'd0));  // park on a jump to itself
        load_program();
        build_expected();
        got = 0;
        @(posedge clk);
        run <= 1'b1;
        while (got < expected_q.size()) begin
            @(negedge clk);
            if (retire_valid) begin
                obs.pc      = retire_pc;
                obs.inst    = retire_inst;
                obs.rd_we   = retire_rd_we;
                obs.rd      = retire_rd;
                obs.rd_data = retire_rd_data;
                compare_retire(obs, expected_q[got], name);
                got++;
            end
        end
        @(posedge clk);
        run <= 1'b0;
        apply_reset();
        prog_q.delete();
    endtask

    task automatic idle_while_stopped();
        repeat (8) begin
            @(negedge clk);
            compare_word(`XLEN'(retire_valid), '0, "retire_valid with run low");
        end
    endtask

    task automatic arith_ops();
        for (int r = 1; r <= 4; r++) begin
            append_inst(i_type(rv_isa_pkg::OP_IMM, 5'(r), 3'b000, 5'd0, 12'(next_bits(12))));
        end
        append_inst(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd5));   // add
        append_inst(r_type(7'h20, 5'd4, 5'd3, 3'b000, 5'd6));   // sub
        append_inst(r_type(7'h00, 5'd2, 5'd5, 3'b111, 5'd7));   // and
        append_inst(r_type(7'h00, 5'd1, 5'd6, 3'b110, 5'd8));   // or
        append_inst(r_type(7'h00, 5'd8, 5'd7, 3'b100, 5'd9));   // xor
        append_inst(r_type(7'h00, 5'd4, 5'd3, 3'b010, 5'd10));  // slt both ways
        append_inst(r_type(7'h00, 5'd3, 5'd4, 3'b010, 5'd11));
        append_inst(i_type(rv_isa_pkg::OP_IMM, 5'd0, 3'b000, 5'd1, 12'(next_bits(12))));
        append_inst(r_type(7'h00, 5'd9, 5'd0, 3'b000, 5'd12));  // x0 reads zero
        append_inst(r_type(7'h20, 5'd1, 5'd0, 3'b000, 5'd13));
        run_program("arith");
    endtask

    task automatic upper_imms();
        append_inst(u_type(rv_isa_pkg::OP_LUI, 5'd1, 20'(next_bits(20))));
        append_inst(u_type(rv_isa_pkg::OP_AUIPC, 5'd2, 20'(next_bits(20))));
        append_inst(u_type(rv_isa_pkg::OP_LUI, 5'd3, 20'(next_bits(20))));
        append_inst(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd4));
        append_inst(u_type(rv_isa_pkg::OP_AUIPC, 5'd5, 20'h0));
        run_program("upper");
    endtask

    // each branch skips one addi when taken
    task automatic branch_outcomes();
        append_inst(i_type(rv_isa_pkg::OP_IMM, 5'd1, 3'b000, 5'd0, 12'hFFB));  // -5
        append_inst(i_type(rv_isa_pkg::OP_IMM, 5'd2, 3'b000, 5'd0, 12'h007));
        append_inst(i_type(rv_isa_pkg::OP_IMM, 5'd3, 3'b000, 5'd0, 12'hFFB));
        append_inst(b_type(3'b000, 5'd1, 5'd3, 13'd8));  // beq taken
        append_inst(i_type(rv_isa_pkg::OP_IMM, 5'd10, 3'b000, 5'd0, 12'h001));
        append_inst(b_type(3'b000, 5'd1, 5'd2, 13'd8));  // beq falls through
        append_inst(i_type(rv_isa_pkg::OP_IMM, 5'd11, 3'b000, 5'd0, 12'h002));
        append_inst(b_type(3'b001, 5'd1, 5'd2, 13'd8));  // bne taken
        append_inst(i_type(rv_isa_pkg::OP_IMM, 5'd12, 3'b000, 5'd0, 12'h003));
        append_inst(b_type(3'b001, 5'd1, 5'd3, 13'd8));
        append_inst(i_type(rv_isa_pkg::OP_IMM, 5'd13, 3'b000, 5'd0, 12'h004));
        append_inst(b_type(3'b100, 5'd1, 5'd2, 13'd8));  // blt taken as -5 < 7 signed
        append_inst(i_type(rv_isa_pkg::OP_IMM, 5'd14, 3'b000, 5'd0, 12'h005));
        append_inst(b_type(3'b100, 5'd2, 5'd1, 13'd8));
        append_inst(i_type(rv_isa_pkg::OP_IMM, 5'd15, 3'b000, 5'd0, 12'h006));
        append_inst(b_type(3'b101, 5'd2, 5'd1, 13'd8));  // bge taken
        append_inst(i_type(rv_isa_pkg::OP_IMM, 5'd16, 3'b000, 5'd0, 12'h007));
        append_inst(b_type(3'b101, 5'd1, 5'd2, 13'd8));
        append_inst(i_type(rv_isa_pkg::OP_IMM, 5'd17, 3'b000, 5'd0, 12'h008));
        run_program("branch");
    endtask

    task automatic jumps_and_links();
        append_inst(j_type(5'd1, 21'd12));                                      // to 12
        append_inst(i_type(rv_isa_pkg::OP_IMM, 5'd10, 3'b000, 5'd0, 12'h001));
        append_inst(i_type(rv_isa_pkg::OP_IMM, 5'd11, 3'b000, 5'd0, 12'h001));
        append_inst(i_type(rv_isa_pkg::OP_IMM, 5'd5, 3'b000, 5'd0, 12'd25));   // odd target
        append_inst(i_type(rv_isa_pkg::OP_JALR, 5'd2, 3'b000, 5'd5, 12'h000));
        append_inst(i_type(rv_isa_pkg::OP_IMM, 5'd12, 3'b000, 5'd0, 12'h001));
        append_inst(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd6));                  // at 24
        run_program("jump");
    endtask

    task automatic long_straight_run();
        for (int i = 0; i < 40; i++) begin
            append_inst(i_type(rv_isa_pkg::OP_IMM, 5'(1 + i % 8), 3'b000,
                               5'(1 + (i + 7) % 8), 12'(next_bits(12))));
        end
        run_program("long");
    endtask

    initial begin
        arst_n       = 1'b0;
        run          = 1'b0;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_wdata   = '0;
        lfsr         = 32'h4259_e2cb;
        cycles       = 0;
        check_count  = 0;
        error_count  = 0;
        assert_fails = 0;
        apply_reset();
        idle_while_stopped();
        arith_ops();
        upper_imms();
        branch_outcomes();
        jumps_and_links();
        long_straight_run();
        assert_fails = u_mini_core_top.u_fetch_queue.u_fetch_queue_sva.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d", check_count, error_count,
                 assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/fetch_queue_if.sv
hdl/fetch_unit.sv
hdl/fetch_queue.sv
hdl/exec_unit.sv
hdl/mini_core_top.sv
tests/mini_core_sva.sv
tests/mini_core_tb.sv

//--- Bender.yml
package:
  name: mini_core

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/rv_isa_pkg.sv
      - hdl/core_pkg.sv
      - hdl/fetch_queue_if.sv
      - hdl/fetch_unit.sv
      - hdl/fetch_queue.sv
      - hdl/exec_unit.sv
      - hdl/mini_core_top.sv
  - target: test
    files:
      - tests/mini_core_sva.sv
      - tests/mini_core_tb.sv
